// File: hw/lsu_pkg.sv
// Shared definitions for the load/store unit
// Data, address and byte-enable types, access size enum,
// bufferable region bounds and outstanding-entry fields
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////////////////////////////////////////

  // Byte address
  typedef logic [31:0] addr_t;
  // Bus and register data
  typedef logic [31:0] data_t;
  // One enable per byte lane
  typedef logic [3:0]  be_t;
  // Byte offset inside a word
  typedef logic [1:0]  ofs_t;

  // Access size as issued by the core
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

  ////////////////////////////////////////////////////////////////////////////
  // Bufferable region, both bounds inclusive
  ////////////////////////////////////////////////////////////////////////////

  localparam addr_t BUF_BASE  = 32'h0000_8000;
  localparam addr_t BUF_LIMIT = 32'h0000_FFFF;

  // Outstanding entry, one bit each for bufferable and store
  localparam int OST_BUF   = 0;
  localparam int OST_STORE = 1;
  localparam int OST_W     = 2;

  typedef logic [OST_W-1:0] ost_t;

endpackage

`default_nettype wire

// File: hw/lsu_req_stage.sv
// One-entry request register on the core side
// Builds word address, byte enables and lane-replicated write data
// Marks stores inside the bufferable region
`timescale 1ns/1ns
`default_nettype none

module lsu_req_stage (
  input  wire                 clk,
  input  wire                 rst_n,
  // Core request
  input  wire                 core_req_valid_i,
  output logic                core_req_ready_o,
  input  wire lsu_pkg::addr_t core_addr_i,
  input  wire                 core_we_i,
  input  wire lsu_pkg::size_e core_size_i,
  input  wire                 core_sign_i,
  input  wire lsu_pkg::data_t core_wdata_i,
  // Request towards the filter and the bus
  output logic                req_valid_o,
  input  wire                 req_ready_i,
  output lsu_pkg::addr_t      req_addr_o,
  output logic                req_we_o,
  output lsu_pkg::be_t        req_be_o,
  output lsu_pkg::data_t      req_wdata_o,
  output logic                req_bufferable_o,
  // Load attributes for the response side
  output lsu_pkg::size_e      req_size_o,
  output logic                req_sign_o,
  output lsu_pkg::ofs_t       req_ofs_o
);

  typedef enum logic {ST_EMPTY, ST_FULL} state_e;

  state_e         state_q;
  state_e         state_d;
  logic           core_acc;
  logic           down_acc;
  lsu_pkg::be_t   be_d;
  lsu_pkg::data_t wdata_d;
  logic           in_region;

  // Ready while empty, or while the held entry leaves this cycle
  assign core_req_ready_o = (state_q == ST_EMPTY) || req_ready_i;
  assign req_valid_o      = (state_q == ST_FULL);
  assign core_acc         = core_req_valid_i && core_req_ready_o;
  assign down_acc         = req_valid_o && req_ready_i;

  // Region check on the byte address
  assign in_region = (core_addr_i >= lsu_pkg::BUF_BASE) && (core_addr_i <= lsu_pkg::BUF_LIMIT);

  // Byte enables and write data lanes from size and offset
  always_comb begin
    case (core_size_i)
      lsu_pkg::SIZE_BYTE: begin
        be_d    = 4'b0001 << core_addr_i[1:0];
        wdata_d = {4{core_wdata_i[7:0]}};
      end
      lsu_pkg::SIZE_HALF: begin
        // Halfword sits in the upper or lower lane pair
        be_d    = core_addr_i[1] ? 4'b1100 : 4'b0011;
        wdata_d = {2{core_wdata_i[15:0]}};
      end
      default: begin
        be_d    = 4'b1111;
        wdata_d = core_wdata_i;
      end
    endcase
  end

  // Entry state
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_EMPTY: if (core_acc) state_d = ST_FULL;
      ST_FULL:  if (down_acc && !core_acc) state_d = ST_EMPTY;
      default:  state_d = ST_EMPTY;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload, loaded on every core accept
  always_ff @(posedge clk) begin
    if (core_acc) begin
      req_addr_o       <= {core_addr_i[31:2], 2'b00};
      req_we_o         <= core_we_i;
      req_be_o         <= be_d;
      req_wdata_o      <= wdata_d;
      req_bufferable_o <= core_we_i && in_region;
      req_size_o       <= core_size_i;
      req_sign_o       <= core_sign_i;
      req_ofs_o        <= core_addr_i[1:0];
    end
  end

endmodule

`default_nettype wire

// File: hw/lsu_resp_filter.sv
// Response filter between request stage and data bus
// Core-side and bus-side outstanding counters with DEPTH limit
// Early response for bufferable stores, bus error and protocol error
`timescale 1ns/1ns
`default_nettype none

module lsu_resp_filter #(
  parameter int unsigned DEPTH = 2
) (
  input  wire  clk,
  input  wire  rst_n,
  // Request side
  input  wire  valid_i,
  input  wire  bufferable_i,
  input  wire  store_i,
  output logic ready_o,
  // Bus request handshake
  output logic bus_valid_o,
  input  wire  bus_ready_i,
  // Bus response
  input  wire  bus_resp_valid_i,
  input  wire  bus_err_i,
  // Core response and status
  output logic resp_valid_o,
  output logic busy_o,
  output logic protocol_err_o,
  output logic err_o,
  output logic err_store_o
);

  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(DEPTH);

  logic [CNT_W-1:0] core_cnt_q;
  logic [CNT_W-1:0] bus_cnt_q;
  logic             core_acc;
  logic             bus_acc;
  logic             has_room;
  logic             bus_oldest_buf;
  logic             core_oldest_buf;

  // Newest transfer at index 1, oldest at the count, index 0 stays zero
  lsu_pkg::ost_t [DEPTH:0] ost_q;
  lsu_pkg::ost_t [DEPTH:0] ost_d;

  // Count one up and one down, never below zero
  function automatic logic [CNT_W-1:0] next_cnt(input logic [CNT_W-1:0] cnt,
                                                input logic             up,
                                                input logic             down);
    logic [CNT_W-1:0] res;
    res = cnt;
    if (up) res = res + CNT_W'(1);
    if (down && (cnt != '0)) res = res - CNT_W'(1);
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Handshake gating
  ////////////////////////////////////////////////////////////////////////////

  // Both sides see the same limit, so the two accepts always coincide
  assign has_room    = (bus_cnt_q < DEPTH_CNT);
  assign ready_o     = bus_ready_i && has_room;
  assign bus_valid_o = valid_i && has_room;
  assign core_acc    = valid_i && ready_o;
  assign bus_acc     = bus_valid_o && bus_ready_i;

  assign busy_o = (bus_cnt_q != '0) || valid_i;

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding shift register and counters
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ost_d = ost_q;
    if (bus_acc) begin
      ost_d[DEPTH:1] = ost_q[DEPTH-1:0];
      ost_d[1]       = {store_i, bufferable_i};
      ost_d[0]       = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_cnt_q <= '0;
      bus_cnt_q  <= '0;
      ost_q      <= '0;
    end else begin
      core_cnt_q <= next_cnt(core_cnt_q, core_acc, resp_valid_o);
      bus_cnt_q  <= next_cnt(bus_cnt_q, bus_acc, bus_resp_valid_i);
      ost_q      <= ost_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response selection
  ////////////////////////////////////////////////////////////////////////////

  assign bus_oldest_buf  = ost_q[bus_cnt_q][lsu_pkg::OST_BUF];
  assign core_oldest_buf = ost_q[core_cnt_q][lsu_pkg::OST_BUF];

  // Bufferable oldest on the bus: answer the core on its own bufferable head
  // Otherwise the bus response passes through
  assign resp_valid_o = bus_oldest_buf ? core_oldest_buf : bus_resp_valid_i;

  // Any bus error, typed by the transfer it belongs to
  assign err_o       = bus_resp_valid_i && bus_err_i;
  assign err_store_o = ost_q[bus_cnt_q][lsu_pkg::OST_STORE];

  // Response with nothing outstanding on the matching side
  assign protocol_err_o = (resp_valid_o && (core_cnt_q == '0)) ||
                          (bus_resp_valid_i && (bus_cnt_q == '0));

endmodule

`default_nettype wire

// File: hw/lsu_resp_stage.sv
// Core response side of the load/store unit
// Queue of load attributes per accepted request
// Load data alignment with sign extension, sticky error status
`timescale 1ns/1ns
`default_nettype none

module lsu_resp_stage #(
  parameter int unsigned DEPTH = 2
) (
  input  wire                 clk,
  input  wire                 rst_n,
  // Attributes of the request accepted this cycle
  input  wire                 push_i,
  input  wire lsu_pkg::size_e size_i,
  input  wire                 sign_i,
  input  wire lsu_pkg::ofs_t  ofs_i,
  input  wire                 store_i,
  // Response from filter and bus
  input  wire                 resp_valid_i,
  input  wire lsu_pkg::data_t bus_rdata_i,
  input  wire                 bus_err_i,
  input  wire                 err_i,
  input  wire                 err_store_i,
  input  wire                 protocol_err_i,
  input  wire                 err_clear_i,
  // Core response
  output logic                core_resp_valid_o,
  output lsu_pkg::data_t      core_rdata_o,
  output logic                core_err_o,
  // Status
  output logic                err_valid_o,
  output logic                err_store_o,
  output logic                protocol_err_o
);

  localparam int unsigned IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [IDX_W-1:0] LAST_IDX  = IDX_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(DEPTH);

  lsu_pkg::size_e   size_q  [DEPTH];
  logic             sign_q  [DEPTH];
  lsu_pkg::ofs_t    ofs_q   [DEPTH];
  logic             store_q [DEPTH];
  logic [IDX_W-1:0] wr_ptr_q;
  logic [IDX_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push;
  logic             do_pop;
  lsu_pkg::data_t   shifted;
  logic             ext;

  ////////////////////////////////////////////////////////////////////////////
  // Attribute queue, in request order
  ////////////////////////////////////////////////////////////////////////////

  assign do_push = push_i && (cnt_q != DEPTH_CNT);
  // Spurious responses leave the queue alone
  assign do_pop  = resp_valid_i && (cnt_q != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + IDX_W'(1);
      if (do_pop)  rd_ptr_q <= (rd_ptr_q == LAST_IDX) ? '0 : rd_ptr_q + IDX_W'(1);
      cnt_q <= cnt_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      size_q[wr_ptr_q]  <= size_i;
      sign_q[wr_ptr_q]  <= sign_i;
      ofs_q[wr_ptr_q]   <= ofs_i;
      store_q[wr_ptr_q] <= store_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Load data alignment
  ////////////////////////////////////////////////////////////////////////////

  assign core_resp_valid_o = resp_valid_i;

  always_comb begin
    // Bring the addressed bytes down to lane 0
    shifted = bus_rdata_i >> {ofs_q[rd_ptr_q], 3'b000};
    ext     = 1'b0;
    case (size_q[rd_ptr_q])
      lsu_pkg::SIZE_BYTE: begin
        ext          = sign_q[rd_ptr_q] && shifted[7];
        core_rdata_o = {{24{ext}}, shifted[7:0]};
      end
      lsu_pkg::SIZE_HALF: begin
        ext          = sign_q[rd_ptr_q] && shifted[15];
        core_rdata_o = {{16{ext}}, shifted[15:0]};
      end
      default: core_rdata_o = shifted;
    endcase
    // Stores carry no data back
    if (store_q[rd_ptr_q]) core_rdata_o = '0;
  end

  // Error on loads only, an early store answer never carries one
  assign core_err_o = resp_valid_i && bus_err_i && !err_store_i;

  // Sticky status, a new error wins over a clear in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_valid_o    <= 1'b0;
      err_store_o    <= 1'b0;
      protocol_err_o <= 1'b0;
    end else begin
      if (err_i) begin
        err_valid_o <= 1'b1;
        err_store_o <= err_store_i;
      end else if (err_clear_i) begin
        err_valid_o <= 1'b0;
        err_store_o <= 1'b0;
      end
      if (protocol_err_i) protocol_err_o <= 1'b1;
      else if (err_clear_i) protocol_err_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hw/lsu_top.sv
// Load/store unit top level
// Request stage, response filter and response stage
`timescale 1ns/1ns
`default_nettype none

module lsu_top #(
  parameter int unsigned DEPTH = 2
) (
  input  wire                 clk,
  input  wire                 rst_n,
  // Core request and response
  input  wire                 core_req_valid_i,
  output logic                core_req_ready_o,
  input  wire lsu_pkg::addr_t core_addr_i,
  input  wire                 core_we_i,
  input  wire lsu_pkg::size_e core_size_i,
  input  wire                 core_sign_i,
  input  wire lsu_pkg::data_t core_wdata_i,
  output logic                core_resp_valid_o,
  output lsu_pkg::data_t      core_rdata_o,
  output logic                core_err_o,
  // Data bus
  output logic                bus_req_valid_o,
  input  wire                 bus_req_ready_i,
  output lsu_pkg::addr_t      bus_addr_o,
  output logic                bus_we_o,
  output lsu_pkg::be_t        bus_be_o,
  output lsu_pkg::data_t      bus_wdata_o,
  input  wire                 bus_resp_valid_i,
  input  wire lsu_pkg::data_t bus_rdata_i,
  input  wire                 bus_err_i,
  // Status
  output logic                busy_o,
  output logic                err_valid_o,
  output logic                err_store_o,
  output logic                protocol_err_o,
  input  wire                 err_clear_i
);

  wire                 req_valid;
  wire                 req_ready;
  wire                 req_we;
  wire                 req_bufferable;
  wire lsu_pkg::size_e req_size;
  wire                 req_sign;
  wire lsu_pkg::ofs_t  req_ofs;
  wire                 resp_valid;
  wire                 filt_err;
  wire                 filt_err_store;
  wire                 filt_proto_err;
  // Core-side accept of the filter, pushes the load attributes
  wire                 req_accept = req_valid && req_ready;

  assign bus_we_o = req_we;

  lsu_req_stage u_req_stage (
    .clk(clk), .rst_n(rst_n),
    .core_req_valid_i(core_req_valid_i), .core_req_ready_o(core_req_ready_o),
    .core_addr_i(core_addr_i), .core_we_i(core_we_i), .core_size_i(core_size_i),
    .core_sign_i(core_sign_i), .core_wdata_i(core_wdata_i),
    .req_valid_o(req_valid), .req_ready_i(req_ready),
    .req_addr_o(bus_addr_o), .req_we_o(req_we), .req_be_o(bus_be_o),
    .req_wdata_o(bus_wdata_o), .req_bufferable_o(req_bufferable),
    .req_size_o(req_size), .req_sign_o(req_sign), .req_ofs_o(req_ofs)
  );

  lsu_resp_filter #(.DEPTH(DEPTH)) u_resp_filter (
    .clk(clk), .rst_n(rst_n),
    .valid_i(req_valid), .bufferable_i(req_bufferable), .store_i(req_we),
    .ready_o(req_ready), .bus_valid_o(bus_req_valid_o), .bus_ready_i(bus_req_ready_i),
    .bus_resp_valid_i(bus_resp_valid_i), .bus_err_i(bus_err_i),
    .resp_valid_o(resp_valid), .busy_o(busy_o), .protocol_err_o(filt_proto_err),
    .err_o(filt_err), .err_store_o(filt_err_store)
  );

  lsu_resp_stage #(.DEPTH(DEPTH)) u_resp_stage (
    .clk(clk), .rst_n(rst_n),
    .push_i(req_accept), .size_i(req_size), .sign_i(req_sign), .ofs_i(req_ofs),
    .store_i(req_we), .resp_valid_i(resp_valid), .bus_rdata_i(bus_rdata_i),
    .bus_err_i(bus_err_i), .err_i(filt_err), .err_store_i(filt_err_store),
    .protocol_err_i(filt_proto_err), .err_clear_i(err_clear_i),
    .core_resp_valid_o(core_resp_valid_o), .core_rdata_o(core_rdata_o),
    .core_err_o(core_err_o), .err_valid_o(err_valid_o), .err_store_o(err_store_o),
    .protocol_err_o(protocol_err_o)
  );

endmodule

`default_nettype wire

// File: tests/lsu_bus_model.sv
// In-order data bus slave for the load/store unit testbench
// Random request ready, random response latency, word memory
// Error injection on one word address, forced spurious response
`timescale 1ns/1ns
`default_nettype none

module lsu_bus_model (
  input  wire                 clk,
  input  wire                 rst_n,
  // Request channel
  input  wire                 req_valid_i,
  output logic                req_ready_o,
  input  wire lsu_pkg::addr_t addr_i,
  input  wire                 we_i,
  input  wire lsu_pkg::be_t   be_i,
  input  wire lsu_pkg::data_t wdata_i,
  // Response channel
  output logic                resp_valid_o,
  output lsu_pkg::data_t      rdata_o,
  output logic                err_o,
  // Test controls
  input  wire                 slow_i,
  input  wire                 err_en_i,
  input  wire lsu_pkg::addr_t err_addr_i,
  input  wire                 spurious_i
);

  lsu_pkg::data_t mem [0:16383];
  lsu_pkg::data_t rsp_data [$];
  logic           rsp_err [$];
  int unsigned    wait_cnt;
  // Values seen in the middle of the cycle, before the edge acts on them
  logic           acc_s;
  lsu_pkg::addr_t addr_s;
  logic           we_s;
  lsu_pkg::be_t   be_s;
  lsu_pkg::data_t wdata_s;
  logic           slow_s;
  logic           err_s;
  logic           spur_s;

  // Initial content depends on the whole word index
  function automatic lsu_pkg::data_t fill_word(input int unsigned idx);
    return (idx * 32'h9E37_79B1) ^ 32'hA5C3_0F17;
  endfunction

  initial begin
    for (int unsigned i = 0; i < 16384; i++) begin
      mem[i] = fill_word(i);
    end
    req_ready_o  = 1'b0;
    resp_valid_o = 1'b0;
    rdata_o      = '0;
    err_o        = 1'b0;
    wait_cnt     = 0;
  end

  always @(negedge clk) begin
    acc_s   = req_valid_i && req_ready_o;
    addr_s  = addr_i;
    we_s    = we_i;
    be_s    = be_i;
    wdata_s = wdata_i;
    slow_s  = slow_i;
    err_s   = err_en_i && (addr_i[15:2] == err_addr_i[15:2]);
    spur_s  = spurious_i;
  end

  always @(posedge clk) begin
    if (rst_n && acc_s) begin
      // Writes land and reads sample at accept, in transfer order
      for (int b = 0; b < 4; b++) begin
        if (we_s && be_s[b]) mem[addr_s[15:2]][8*b +: 8] = wdata_s[8*b +: 8];
      end
      rsp_data.push_back(we_s ? '0 : mem[addr_s[15:2]]);
      rsp_err.push_back(err_s);
    end
    #2;
    resp_valid_o = 1'b0;
    err_o        = 1'b0;
    if (rst_n && spur_s) begin
      resp_valid_o = 1'b1;
      rdata_o      = '0;
    end else if (rst_n && (rsp_data.size() > 0)) begin
      if (wait_cnt == 0) begin
        resp_valid_o = 1'b1;
        rdata_o      = rsp_data.pop_front();
        err_o        = rsp_err.pop_front();
        wait_cnt     = slow_s ? ($urandom % 13) : ($urandom % 3);
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
    req_ready_o = slow_s ? ($urandom % 2 == 0) : ($urandom % 4 != 0);
  end

endmodule

`default_nettype wire

// File: tests/lsu_sva.sv
// Assertions on the response filter, bound into lsu_resp_filter
// Outstanding limit, counter order and request handshake rules
`timescale 1ns/1ns
`default_nettype none

module lsu_sva #(
  parameter int unsigned DEPTH = 2
) (
  input wire                         clk,
  input wire                         rst_n,
  input wire                         valid_i,
  input wire                         ready_o,
  input wire                         bus_valid_o,
  input wire                         bus_ready_i,
  input wire [$clog2(DEPTH+1)-1:0]   bus_cnt_i,
  input wire [$clog2(DEPTH+1)-1:0]   core_cnt_i
);

  // Never more than DEPTH transfers on the bus
  a_bus_limit: assert property (@(posedge clk) disable iff (!rst_n)
    bus_cnt_i <= DEPTH)
    else $error("bus outstanding count above DEPTH");

  // Early answers only ever run ahead of the bus
  a_cnt_order: assert property (@(posedge clk) disable iff (!rst_n)
    core_cnt_i <= bus_cnt_i)
    else $error("core count above bus count");

  // Bus request held until the bus takes it
  a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_valid_o && !bus_ready_i) |=> bus_valid_o)
    else $error("bus request dropped before accept");

  // Request held until taken
  a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (valid_i && !ready_o) |=> valid_i)
    else $error("request dropped before accept");

endmodule

`default_nettype wire

// File: tests/lsu_tb.sv
// Testbench for the load/store unit
// Clock, reset, directed and random stimulus, reference model,
// in-order response checker and final report
`timescale 1ns/1ns
`default_nettype none

module lsu_tb;

  localparam int unsigned DEPTH   = 2;
  localparam int          TIMEOUT = 2000;

  logic clk;
  logic rst_n;
  logic core_req_valid_i;
  logic core_req_ready_o;
  lsu_pkg::addr_t core_addr_i;
  logic core_we_i;
  lsu_pkg::size_e core_size_i;
  logic core_sign_i;
  lsu_pkg::data_t core_wdata_i;
  logic core_resp_valid_o;
  lsu_pkg::data_t core_rdata_o;
  logic core_err_o;
  logic bus_req_valid_o;
  logic bus_req_ready_i;
  lsu_pkg::addr_t bus_addr_o;
  logic bus_we_o;
  lsu_pkg::be_t bus_be_o;
  lsu_pkg::data_t bus_wdata_o;
  logic bus_resp_valid_i;
  lsu_pkg::data_t bus_rdata_i;
  logic bus_err_i;
  logic busy_o;
  logic err_valid_o;
  logic err_store_o;
  logic protocol_err_o;
  logic err_clear_i;
  // Bus model controls
  logic slow;
  logic err_en;
  lsu_pkg::addr_t err_addr;
  logic spurious;

  lsu_pkg::data_t ref_mem [0:16383];
  lsu_pkg::data_t exp_data [$];
  logic           exp_err [$];
  int unsigned    errors;
  int unsigned    checks;
  int unsigned    issued;
  int unsigned    received;
  logic           allow_spurious;
  logic           timed_out;

  lsu_top #(.DEPTH(DEPTH)) UUT (.*);

  lsu_bus_model u_bus (
    .clk(clk), .rst_n(rst_n),
    .req_valid_i(bus_req_valid_o), .req_ready_o(bus_req_ready_i),
    .addr_i(bus_addr_o), .we_i(bus_we_o), .be_i(bus_be_o), .wdata_i(bus_wdata_o),
    .resp_valid_o(bus_resp_valid_i), .rdata_o(bus_rdata_i), .err_o(bus_err_i),
    .slow_i(slow), .err_en_i(err_en), .err_addr_i(err_addr), .spurious_i(spurious)
  );

  bind lsu_resp_filter lsu_sva #(.DEPTH(DEPTH)) u_sva (
    .clk(clk), .rst_n(rst_n), .valid_i(valid_i), .ready_o(ready_o),
    .bus_valid_o(bus_valid_o), .bus_ready_i(bus_ready_i),
    .bus_cnt_i(bus_cnt_q), .core_cnt_i(core_cnt_q)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Same initial memory image as the bus slave
  function automatic lsu_pkg::data_t fill_word(input int unsigned idx);
    return (idx * 32'h9E37_79B1) ^ 32'hA5C3_0F17;
  endfunction

  // Load result from the memory word, size, sign and byte offset
  function automatic lsu_pkg::data_t load_value(input lsu_pkg::data_t word,
                                                input lsu_pkg::size_e size,
                                                input logic sign,
                                                input lsu_pkg::ofs_t ofs);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*int'(ofs) +: 8];
    h = ofs[1] ? word[31:16] : word[15:0];
    case (size)
      lsu_pkg::SIZE_BYTE: return sign ? {{24{b[7]}}, b} : {24'd0, b};
      lsu_pkg::SIZE_HALF: return sign ? {{16{h[15]}}, h} : {16'd0, h};
      default:            return word;
    endcase
  endfunction

  // Store written byte by byte into the reference memory
  task automatic apply_store(input lsu_pkg::addr_t addr, input lsu_pkg::size_e size,
                             input lsu_pkg::data_t wdata);
    int o;
    o = int'(addr[1:0]);
    case (size)
      lsu_pkg::SIZE_BYTE: ref_mem[addr[15:2]][8*o +: 8] = wdata[7:0];
      lsu_pkg::SIZE_HALF: ref_mem[addr[15:2]][8*o +: 16] = wdata[15:0];
      default:            ref_mem[addr[15:2]] = wdata;
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_data(input string what, input lsu_pkg::data_t got,
                            input lsu_pkg::data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_err(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s error flag %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_status(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: status %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Responses compared in order, sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && core_resp_valid_o && !allow_spurious) begin
      received++;
      if (exp_data.size() == 0) begin
        errors++;
        $display("Core response at %0t ns with no request waiting for one", $time);
      end else begin
        check_data("core_rdata_o", core_rdata_o, exp_data.pop_front());
        check_err("core_err_o", core_err_o, exp_err.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_timeout(input string what);
    timed_out = 1'b1;
    errors++;
    $display("Timeout while waiting for %s at %0t ns", what, $time);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic issue(input lsu_pkg::addr_t addr, input logic we,
                       input lsu_pkg::size_e size, input logic sign,
                       input lsu_pkg::data_t wdata, input logic exp_e);
    int   n;
    logic acc;
    if (we) begin
      exp_data.push_back('0);
      apply_store(addr, size, wdata);
    end else begin
      exp_data.push_back(load_value(ref_mem[addr[15:2]], size, sign, addr[1:0]));
    end
    exp_err.push_back(exp_e);
    core_req_valid_i = 1'b1;
    core_addr_i      = addr;
    core_we_i        = we;
    core_size_i      = size;
    core_sign_i      = sign;
    core_wdata_i     = wdata;
    n   = 0;
    acc = 1'b0;
    while (!acc && (n < TIMEOUT)) begin
      @(negedge clk);
      acc = core_req_ready_o;
      next_cycle();
      n++;
    end
    core_req_valid_i = 1'b0;
    if (acc) issued++;
    else report_timeout("core request accept");
  endtask

  // Aligned random access, inside or outside the bufferable region
  task automatic random_op();
    lsu_pkg::addr_t addr;
    lsu_pkg::size_e size;
    size = lsu_pkg::size_e'(2'($urandom % 3));
    addr = (($urandom % 2) ? 32'h0000_8000 : 32'h0000_0400) + ($urandom % 16) * 4;
    if (size == lsu_pkg::SIZE_BYTE) addr[1:0] = 2'($urandom % 4);
    if (size == lsu_pkg::SIZE_HALF) addr[1] = 1'($urandom % 2);
    issue(addr, 1'($urandom % 2), size, 1'($urandom % 2), $urandom, 1'b0);
  endtask

  // All responses in and the bus side empty
  task automatic drain();
    int n;
    n = 0;
    while (((received < issued) || busy_o) && (n < TIMEOUT)) begin
      next_cycle();
      n++;
    end
    if (n == TIMEOUT) report_timeout("outstanding responses");
    // Normal traffic never raises a protocol error
    check_status("protocol_err_o", protocol_err_o, 1'b0);
  endtask

  task automatic pulse_clear();
    err_clear_i = 1'b1;
    next_cycle();
    err_clear_i = 1'b0;
    next_cycle();
  endtask

  task automatic end_test(input string name, input int unsigned err_before);
    $display("Test %s: %s", name, (errors == err_before) ? "PASS" : "FAIL");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_tests();
    int unsigned e;
    e = errors;
    // Idle after reset
    check_status("busy_o", busy_o, 1'b0);
    for (int s = 0; s < 2; s++) begin
      for (int o = 0; o < 4; o++) begin
        issue(32'h0000_0200 + 4 * o + o, 1'b0, lsu_pkg::SIZE_BYTE, 1'(s), '0, 1'b0);
      end
      issue(32'h0000_0210, 1'b0, lsu_pkg::SIZE_HALF, 1'(s), '0, 1'b0);
      issue(32'h0000_0216, 1'b0, lsu_pkg::SIZE_HALF, 1'(s), '0, 1'b0);
      issue(32'h0000_0220, 1'b0, lsu_pkg::SIZE_WORD, 1'(s), '0, 1'b0);
    end
    drain();
    end_test("1 loads", e);
    if (timed_out) return;

    e = errors;
    issue(32'h0000_0500, 1'b1, lsu_pkg::SIZE_WORD, 1'b0, 32'h1234_5678, 1'b0);
    issue(32'h0000_0501, 1'b1, lsu_pkg::SIZE_BYTE, 1'b0, 32'h0000_00F3, 1'b0);
    issue(32'h0000_0502, 1'b1, lsu_pkg::SIZE_HALF, 1'b0, 32'h0000_8A5C, 1'b0);
    issue(32'h0000_0500, 1'b0, lsu_pkg::SIZE_WORD, 1'b0, '0, 1'b0);
    issue(32'h0000_0501, 1'b0, lsu_pkg::SIZE_BYTE, 1'b1, '0, 1'b0);
    issue(32'h0000_0502, 1'b0, lsu_pkg::SIZE_HALF, 1'b1, '0, 1'b0);
    drain();
    end_test("2 store/load", e);
    if (timed_out) return;

    e = errors;
    for (int i = 0; i < 30; i++) random_op();
    drain();
    check_status("requests answered", (received == issued), 1'b1);
    end_test("3 bufferable order", e);
    if (timed_out) return;

    e = errors;
    slow = 1'b1;
    for (int i = 0; i < 40; i++) random_op();
    drain();
    slow = 1'b0;
    end_test("4 back-pressure", e);
    if (timed_out) return;

    e = errors;
    err_addr = 32'h0000_0300;
    err_en   = 1'b1;
    issue(32'h0000_0300, 1'b0, lsu_pkg::SIZE_WORD, 1'b0, '0, 1'b1);
    // The accepted load sits in the request register
    check_status("busy_o", busy_o, 1'b1);
    drain();
    err_en = 1'b0;
    check_status("err_valid_o", err_valid_o, 1'b1);
    check_status("err_store_o", err_store_o, 1'b0);
    pulse_clear();
    check_status("err_valid_o", err_valid_o, 1'b0);
    err_addr = 32'h0000_8100;
    err_en   = 1'b1;
    issue(32'h0000_8100, 1'b1, lsu_pkg::SIZE_WORD, 1'b0, 32'hCAFE_0001, 1'b0);
    drain();
    err_en = 1'b0;
    check_status("err_valid_o", err_valid_o, 1'b1);
    check_status("err_store_o", err_store_o, 1'b1);
    pulse_clear();
    check_status("err_valid_o", err_valid_o, 1'b0);
    end_test("5 bus errors", e);
    if (timed_out) return;

    e = errors;
    check_status("protocol_err_o", protocol_err_o, 1'b0);
    allow_spurious = 1'b1;
    spurious       = 1'b1;
    next_cycle();
    spurious = 1'b0;
    repeat (3) next_cycle();
    allow_spurious = 1'b0;
    check_status("protocol_err_o", protocol_err_o, 1'b1);
    pulse_clear();
    check_status("protocol_err_o", protocol_err_o, 1'b0);
    end_test("6 protocol error", e);
  endtask

  initial begin
    void'($urandom(32'h532b387e));
    for (int unsigned i = 0; i < 16384; i++) ref_mem[i] = fill_word(i);
    errors = 0;
    checks = 0;
    issued = 0;
    received = 0;
    allow_spurious = 1'b0;
    timed_out = 1'b0;
    rst_n = 1'b0;
    core_req_valid_i = 1'b0;
    core_addr_i = '0;
    core_we_i = 1'b0;
    core_size_i = lsu_pkg::SIZE_WORD;
    core_sign_i = 1'b0;
    core_wdata_i = '0;
    err_clear_i = 1'b0;
    slow = 1'b0;
    err_en = 1'b0;
    err_addr = '0;
    spurious = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    next_cycle();
    run_tests();
    $display("Checks: %0d, errors: %0d, responses: %0d of %0d",
             checks, errors, received, issued);
    if ((errors == 0) && !timed_out) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
hw/lsu_pkg.sv
hw/lsu_req_stage.sv
hw/lsu_resp_filter.sv
hw/lsu_resp_stage.sv
hw/lsu_top.sv
tests/lsu_bus_model.sv
tests/lsu_sva.sv
tests/lsu_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the load/store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module lsu_tb -o lsu_sim

./obj_dir/lsu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi

if ! grep -q "All tests passed!" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0
